// ==== common/hci_pkg.sv ====
package hci_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////
  localparam int DATA_W     = 8;   // Host and CPU data byte
  localparam int ADDR_W     = 16;  // CPU address bus
  localparam int CNT_W      = 17;  // Doubled byte count for reads
  localparam int REG_SEL_W  = 4;   // Debug register select
  localparam int FIFO_DEPTH = 16;  // Input buffer entries
  localparam int FIFO_AW    = 4;   // Input buffer pointer width

  // Sticky error code bits
  localparam int ERR_UNKNOWN_OP = 1;

  ////////////////////////////////////////////////////////////
  // Packet opcodes
  ////////////////////////////////////////////////////////////
  typedef enum logic [7:0] {
    ECHO           = 8'h00,  // CNT_LO CNT_HI DATA...
    CPU_MEM_RD     = 8'h01,  // ADDR_LO ADDR_HI CNT_LO CNT_HI
    CPU_MEM_WR     = 8'h02,  // ADDR_LO ADDR_HI CNT_LO CNT_HI DATA...
    DBG_BRK        = 8'h03,
    DBG_RUN        = 8'h04,
    CPU_REG_RD     = 8'h05,  // REG_SEL
    CPU_REG_WR     = 8'h06,  // REG_SEL DATA
    QUERY_DBG_BRK  = 8'h07,
    QUERY_ERR_CODE = 8'h08
  } opcode_e;

  ////////////////////////////////////////////////////////////
  // Command controller states
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    S_DISABLED,     // CPU runs, only break is honored
    S_DECODE,       // Waiting for an opcode
    S_ECHO_HDR,
    S_ECHO_DATA,
    S_MEM_RD_HDR,
    S_MEM_RD_DATA,  // Alternating dummy and data cycles
    S_MEM_WR_HDR,
    S_MEM_WR_DATA,
    S_REG_RD,
    S_REG_WR_SEL,
    S_REG_WR_DATA,
    S_QUERY_ERR
  } state_e;

  // Reply byte sources
  typedef enum logic [2:0] {
    SRC_RX,       // Buffer head byte
    SRC_CPU_DIN,  // CPU data bus
    SRC_DBGREG,   // Debug register read bus
    SRC_ERR,      // Sticky error code
    SRC_BRK_ON,   // Constant 0x01
    SRC_BRK_OFF   // Constant 0x00
  } reply_src_e;

endpackage

// ==== host_link/host_fifo.sv ====
`timescale 1ns/1ns

module host_fifo
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [hci_pkg::DATA_W-1:0] host_data,   // Byte from host
  input  logic                       host_valid,
  input  logic                       rx_pop,      // Controller takes head byte
  output logic                       host_ready,  // Room for one more byte
  output logic [hci_pkg::DATA_W-1:0] rx_data,     // Head byte, no latency
  output logic                       rx_empty
);

  logic [hci_pkg::DATA_W-1:0]  mem [hci_pkg::FIFO_DEPTH];
  logic [hci_pkg::FIFO_AW-1:0] wr_ptr;
  logic [hci_pkg::FIFO_AW-1:0] rd_ptr;
  logic [hci_pkg::FIFO_AW:0]   count;  // One extra bit to tell full from empty
  logic                        push;
  logic                        pop;

  assign push = host_valid && host_ready;
  assign pop  = rx_pop && !rx_empty;  // Guard against a stray pop

  // Storage array
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= host_data;
  end

  // Pointers and occupancy
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at FIFO_DEPTH
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Push with pop keeps fill level
      endcase
    end
  end

  assign rx_data    = mem[rd_ptr];
  assign rx_empty   = (count == '0);
  assign host_ready = (count != hci_pkg::FIFO_DEPTH);

endmodule

// ==== ctrl/xfer_counter.sv ====
`timescale 1ns/1ns

module xfer_counter
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic [hci_pkg::DATA_W-1:0] load_byte,  // Packet byte being popped
  input  logic                       addr_ld_lo,
  input  logic                       addr_ld_hi,
  input  logic                       cnt_ld_lo,
  input  logic                       cnt_ld_hi,
  input  logic                       cnt_dbl,    // Read, two cycles per byte
  input  logic                       cnt_step,
  input  logic                       addr_step,
  output logic [hci_pkg::ADDR_W-1:0] addr,
  output logic                       cnt_phase,  // High on read data cycle
  output logic                       cnt_last    // Current step ends the run
);

  logic [hci_pkg::CNT_W-1:0] cnt;
  logic [hci_pkg::CNT_W-1:0] cnt_hi_val;  // Count as it will be after a high load

  // High-byte load, doubled for reads
  always_comb
  begin
    if (cnt_dbl)
      cnt_hi_val = {load_byte, cnt[7:0], 1'b0};
    else
      cnt_hi_val = {1'b0, load_byte, cnt[7:0]};
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      addr <= '0;
      cnt  <= '0;
    end
    else
    begin
      if (addr_ld_lo)
        addr <= {{(hci_pkg::ADDR_W-hci_pkg::DATA_W){1'b0}}, load_byte};
      else if (addr_ld_hi)
        addr <= {load_byte, addr[7:0]};
      else if (addr_step)
        addr <= addr + 1'b1;  // Next byte of the block

      if (cnt_ld_lo)
        cnt <= {{(hci_pkg::CNT_W-hci_pkg::DATA_W){1'b0}}, load_byte};
      else if (cnt_ld_hi)
        cnt <= cnt_hi_val;
      else if (cnt_step)
        cnt <= cnt - 1'b1;
    end
  end

  // Zero count on a header load means no data phase
  assign cnt_last  = cnt_ld_hi ? (cnt_hi_val == '0) : (cnt == 1);
  assign cnt_phase = cnt[0];

endmodule

// ==== ctrl/hci_ctrl.sv ====
`timescale 1ns/1ns

module hci_ctrl
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          brk,         // CPU-initiated break
  input  logic [hci_pkg::DATA_W-1:0]    rx_data,
  input  logic                          rx_empty,
  input  logic                          reply_full,
  input  logic                          cnt_phase,
  input  logic                          cnt_last,
  output logic                          rx_pop,
  output logic                          addr_ld_lo,
  output logic                          addr_ld_hi,
  output logic                          cnt_ld_lo,
  output logic                          cnt_ld_hi,
  output logic                          cnt_dbl,
  output logic                          cnt_step,
  output logic                          addr_step,
  output logic                          reply_req,
  output hci_pkg::reply_src_e           reply_src,
  output logic [hci_pkg::DATA_W-1:0]    err_code,
  output logic                          active,      // CPU held in debug
  output logic                          cpu_r_nw,
  output logic [hci_pkg::REG_SEL_W-1:0] cpu_dbgreg_sel,
  output logic                          cpu_dbgreg_wr
);

  hci_pkg::state_e               state_q, state_d;
  logic [2:0]                    stage_q, stage_d;      // Header byte index
  logic [hci_pkg::DATA_W-1:0]    err_q, err_d;
  logic [hci_pkg::REG_SEL_W-1:0] reg_sel_q, reg_sel_d;  // Select for register write

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= hci_pkg::S_DISABLED;
      stage_q   <= '0;
      err_q     <= '0;
      reg_sel_q <= '0;
    end
    else
    begin
      state_q   <= state_d;
      stage_q   <= stage_d;
      err_q     <= err_d;
      reg_sel_q <= reg_sel_d;
    end
  end

  always_comb
  begin
    state_d   = state_q;
    stage_d   = stage_q;
    err_d     = err_q;
    reg_sel_d = reg_sel_q;

    rx_pop         = 1'b0;
    addr_ld_lo     = 1'b0;
    addr_ld_hi     = 1'b0;
    cnt_ld_lo      = 1'b0;
    cnt_ld_hi      = 1'b0;
    cnt_step       = 1'b0;
    addr_step      = 1'b0;
    reply_req      = 1'b0;
    reply_src      = hci_pkg::SRC_RX;
    cpu_r_nw       = 1'b1;
    cpu_dbgreg_sel = '0;
    cpu_dbgreg_wr  = 1'b0;

    case (state_q)
      ////////////////////////////////////////////////////////////
      // Mode switch and opcode decode
      ////////////////////////////////////////////////////////////
      hci_pkg::S_DISABLED:
      begin
        if (brk)
          state_d = hci_pkg::S_DECODE;
        else if (!rx_empty)
        begin
          if (rx_data == hci_pkg::QUERY_DBG_BRK)
          begin
            if (!reply_full)  // Hold the query until the reply fits
            begin
              rx_pop    = 1'b1;
              reply_req = 1'b1;
              reply_src = hci_pkg::SRC_BRK_OFF;
            end
          end
          else
          begin
            rx_pop = 1'b1;  // Anything else is dropped
            if (rx_data == hci_pkg::DBG_BRK)
              state_d = hci_pkg::S_DECODE;
          end
        end
      end

      hci_pkg::S_DECODE:
      begin
        if (!rx_empty && !(rx_data == hci_pkg::QUERY_DBG_BRK && reply_full))
        begin
          rx_pop  = 1'b1;
          stage_d = '0;  // Header starts at address low
          case (rx_data)
            hci_pkg::ECHO:
            begin
              state_d = hci_pkg::S_ECHO_HDR;
              stage_d = 3'd2;  // Echo header is count only
            end
            hci_pkg::CPU_MEM_RD:     state_d = hci_pkg::S_MEM_RD_HDR;
            hci_pkg::CPU_MEM_WR:     state_d = hci_pkg::S_MEM_WR_HDR;
            hci_pkg::DBG_BRK:        state_d = hci_pkg::S_DECODE;
            hci_pkg::DBG_RUN:        state_d = hci_pkg::S_DISABLED;
            hci_pkg::CPU_REG_RD:     state_d = hci_pkg::S_REG_RD;
            hci_pkg::CPU_REG_WR:     state_d = hci_pkg::S_REG_WR_SEL;
            hci_pkg::QUERY_ERR_CODE: state_d = hci_pkg::S_QUERY_ERR;
            hci_pkg::QUERY_DBG_BRK:
            begin
              reply_req = 1'b1;
              reply_src = hci_pkg::SRC_BRK_ON;
            end
            default: err_d[hci_pkg::ERR_UNKNOWN_OP] = 1'b1;  // Sticky
          endcase
        end
      end

      ////////////////////////////////////////////////////////////
      // Header collection, shared by echo and memory commands
      ////////////////////////////////////////////////////////////
      hci_pkg::S_ECHO_HDR, hci_pkg::S_MEM_RD_HDR, hci_pkg::S_MEM_WR_HDR:
      begin
        if (!rx_empty)
        begin
          rx_pop  = 1'b1;
          stage_d = stage_q + 3'd1;
          case (stage_q)
            3'd0:    addr_ld_lo = 1'b1;
            3'd1:    addr_ld_hi = 1'b1;
            3'd2:    cnt_ld_lo  = 1'b1;
            default:
            begin
              cnt_ld_hi = 1'b1;
              if (cnt_last)
                state_d = hci_pkg::S_DECODE;  // Empty run
              else if (state_q == hci_pkg::S_ECHO_HDR)
                state_d = hci_pkg::S_ECHO_DATA;
              else if (state_q == hci_pkg::S_MEM_RD_HDR)
                state_d = hci_pkg::S_MEM_RD_DATA;
              else
                state_d = hci_pkg::S_MEM_WR_DATA;
            end
          endcase
        end
      end

      ////////////////////////////////////////////////////////////
      // Data phases
      ////////////////////////////////////////////////////////////
      hci_pkg::S_ECHO_DATA:
      begin
        if (!rx_empty && !reply_full)
        begin
          rx_pop    = 1'b1;
          reply_req = 1'b1;  // Send popped byte back
          cnt_step  = 1'b1;
          if (cnt_last)
            state_d = hci_pkg::S_DECODE;
        end
      end

      hci_pkg::S_MEM_RD_DATA:
      begin
        if (!cnt_phase)
          cnt_step = 1'b1;  // Dummy cycle lets memory settle
        else if (!reply_full)
        begin
          reply_req = 1'b1;
          reply_src = hci_pkg::SRC_CPU_DIN;
          cnt_step  = 1'b1;
          addr_step = 1'b1;
          if (cnt_last)
            state_d = hci_pkg::S_DECODE;
        end
      end

      hci_pkg::S_MEM_WR_DATA:
      begin
        if (!rx_empty)
        begin
          rx_pop    = 1'b1;
          cpu_r_nw  = 1'b0;  // Popped byte onto CPU bus
          cnt_step  = 1'b1;
          addr_step = 1'b1;
          if (cnt_last)
            state_d = hci_pkg::S_DECODE;
        end
      end

      ////////////////////////////////////////////////////////////
      // Register commands and error query
      ////////////////////////////////////////////////////////////
      hci_pkg::S_REG_RD:
      begin
        if (!rx_empty && !reply_full)
        begin
          rx_pop         = 1'b1;
          cpu_dbgreg_sel = rx_data[hci_pkg::REG_SEL_W-1:0];
          reply_req      = 1'b1;
          reply_src      = hci_pkg::SRC_DBGREG;
          state_d        = hci_pkg::S_DECODE;
        end
      end

      hci_pkg::S_REG_WR_SEL:
      begin
        if (!rx_empty)
        begin
          rx_pop    = 1'b1;
          reg_sel_d = rx_data[hci_pkg::REG_SEL_W-1:0];
          state_d   = hci_pkg::S_REG_WR_DATA;
        end
      end

      hci_pkg::S_REG_WR_DATA:
      begin
        if (!rx_empty)
        begin
          rx_pop         = 1'b1;
          cpu_dbgreg_sel = reg_sel_q;
          cpu_dbgreg_wr  = 1'b1;  // Value is the popped byte
          state_d        = hci_pkg::S_DECODE;
        end
      end

      hci_pkg::S_QUERY_ERR:
      begin
        if (!reply_full)
        begin
          reply_req = 1'b1;
          reply_src = hci_pkg::SRC_ERR;
          state_d   = hci_pkg::S_DECODE;
        end
      end

      default: state_d = hci_pkg::S_DISABLED;
    endcase
  end

  assign cnt_dbl  = (state_q == hci_pkg::S_MEM_RD_HDR);  // Only sampled on high load
  assign err_code = err_q;
  assign active   = (state_q != hci_pkg::S_DISABLED);

endmodule

// ==== src/reply_stage.sv ====
`timescale 1ns/1ns

module reply_stage
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       reply_req,      // Controller sends a byte
  input  hci_pkg::reply_src_e        reply_src,
  input  logic [hci_pkg::DATA_W-1:0] rx_data,        // Echo data
  input  logic [hci_pkg::DATA_W-1:0] cpu_din,        // Memory read data
  input  logic [hci_pkg::DATA_W-1:0] cpu_dbgreg_in,  // Debug register data
  input  logic [hci_pkg::DATA_W-1:0] err_code,
  output logic [hci_pkg::DATA_W-1:0] reply_data,
  output logic                       reply_valid
);

  logic [hci_pkg::DATA_W-1:0] src_byte;

  // Reply byte select
  always_comb
  begin
    case (reply_src)
      hci_pkg::SRC_RX:      src_byte = rx_data;
      hci_pkg::SRC_CPU_DIN: src_byte = cpu_din;
      hci_pkg::SRC_DBGREG:  src_byte = cpu_dbgreg_in;
      hci_pkg::SRC_ERR:     src_byte = err_code;
      hci_pkg::SRC_BRK_ON:  src_byte = 8'h01;  // In debug break
      default:              src_byte = 8'h00;  // Not in break
    endcase
  end

  // Data only moves when requested
  always_ff @(posedge clk)
  begin
    if (reply_req)
      reply_data <= src_byte;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      reply_valid <= 1'b0;
    else
      reply_valid <= reply_req;  // One-cycle strobe
  end

endmodule

// ==== src/hci_top.sv ====
`timescale 1ns/1ns

module hci_top
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic [hci_pkg::DATA_W-1:0]    host_data,
  input  logic                          host_valid,
  input  logic                          reply_full,
  input  logic                          brk,
  input  logic [hci_pkg::DATA_W-1:0]    cpu_din,
  input  logic [hci_pkg::DATA_W-1:0]    cpu_dbgreg_in,
  output logic                          host_ready,
  output logic [hci_pkg::DATA_W-1:0]    reply_data,
  output logic                          reply_valid,
  output logic                          active,
  output logic                          cpu_r_nw,
  output logic [hci_pkg::ADDR_W-1:0]    cpu_a,
  output logic [hci_pkg::DATA_W-1:0]    cpu_dout,
  output logic [hci_pkg::REG_SEL_W-1:0] cpu_dbgreg_sel,
  output logic [hci_pkg::DATA_W-1:0]    cpu_dbgreg_out,
  output logic                          cpu_dbgreg_wr
);

  // Buffer to controller
  logic [hci_pkg::DATA_W-1:0] rx_data;
  logic                       rx_empty;
  logic                       rx_pop;

  // Controller to counter
  logic addr_ld_lo, addr_ld_hi;
  logic cnt_ld_lo, cnt_ld_hi, cnt_dbl;
  logic cnt_step, addr_step;
  logic cnt_phase, cnt_last;

  // Controller to reply stage
  logic                       reply_req;
  hci_pkg::reply_src_e        reply_src;
  logic [hci_pkg::DATA_W-1:0] err_code;

  host_fifo u_host_fifo
  (
    .clk(clk), .rst(rst),
    .host_data(host_data), .host_valid(host_valid), .rx_pop(rx_pop),
    .host_ready(host_ready), .rx_data(rx_data), .rx_empty(rx_empty)
  );

  hci_ctrl u_hci_ctrl
  (
    .clk(clk), .rst(rst), .brk(brk),
    .rx_data(rx_data), .rx_empty(rx_empty), .reply_full(reply_full),
    .cnt_phase(cnt_phase), .cnt_last(cnt_last), .rx_pop(rx_pop),
    .addr_ld_lo(addr_ld_lo), .addr_ld_hi(addr_ld_hi),
    .cnt_ld_lo(cnt_ld_lo), .cnt_ld_hi(cnt_ld_hi), .cnt_dbl(cnt_dbl),
    .cnt_step(cnt_step), .addr_step(addr_step),
    .reply_req(reply_req), .reply_src(reply_src), .err_code(err_code),
    .active(active), .cpu_r_nw(cpu_r_nw),
    .cpu_dbgreg_sel(cpu_dbgreg_sel), .cpu_dbgreg_wr(cpu_dbgreg_wr)
  );

  // Counter address drives the CPU bus directly
  xfer_counter u_xfer_counter
  (
    .clk(clk), .rst(rst), .load_byte(rx_data),
    .addr_ld_lo(addr_ld_lo), .addr_ld_hi(addr_ld_hi),
    .cnt_ld_lo(cnt_ld_lo), .cnt_ld_hi(cnt_ld_hi), .cnt_dbl(cnt_dbl),
    .cnt_step(cnt_step), .addr_step(addr_step),
    .addr(cpu_a), .cnt_phase(cnt_phase), .cnt_last(cnt_last)
  );

  reply_stage u_reply_stage
  (
    .clk(clk), .rst(rst), .reply_req(reply_req), .reply_src(reply_src),
    .rx_data(rx_data), .cpu_din(cpu_din), .cpu_dbgreg_in(cpu_dbgreg_in),
    .err_code(err_code), .reply_data(reply_data), .reply_valid(reply_valid)
  );

  // Write data on both CPU paths is the buffer head
  assign cpu_dout       = rx_data;
  assign cpu_dbgreg_out = rx_data;

endmodule

// ==== test/hci_properties.sv ====
`timescale 1ns/1ns

module hci_properties
(
  input logic                          clk,
  input logic                          rst,
  input logic                          reply_full,
  input logic                          reply_valid,
  input logic                          active,
  input logic                          cpu_r_nw,
  input logic [hci_pkg::ADDR_W-1:0]    cpu_a,
  input logic                          cpu_dbgreg_wr,
  input hci_pkg::state_e               state        // Controller state
);

  int                         fail_cnt = 0;  // Read by the testbench at the end
  logic [hci_pkg::ADDR_W-1:0] prev_wr_a;     // Address of the last CPU write
  logic                       wr_in_pkt;     // A write of this packet was seen

  // Tracks CPU writes inside one memory write packet
  always_ff @(posedge clk)
  begin
    if (rst || state != hci_pkg::S_MEM_WR_DATA)
      wr_in_pkt <= 1'b0;  // Header and other commands clear it
    else if (!cpu_r_nw)
    begin
      wr_in_pkt <= 1'b1;
      prev_wr_a <= cpu_a;
    end
  end

  ////////////////////////////////////////////////////////////
  // Port properties
  ////////////////////////////////////////////////////////////

  // First cycle out of reset
  reset_state: assert property (@(posedge clk)
    ($past(rst) && !rst) |-> (!active && !reply_valid && !cpu_dbgreg_wr && cpu_r_nw))
  else
  begin
    $error("Outputs not in reset state after reset release");
    fail_cnt++;
  end

  // CPU bus is only written in break mode
  no_write_idle: assert property (@(posedge clk) disable iff (rst)
    !active |-> cpu_r_nw)
  else
  begin
    $error("CPU write while not in break mode");
    fail_cnt++;
  end

  // Back-pressure honored
  full_blocks_reply: assert property (@(posedge clk) disable iff (rst)
    reply_full |=> !reply_valid)
  else
  begin
    $error("Reply byte sent while the reply port was full");
    fail_cnt++;
  end

  // Block write walks the address upward
  wr_addr_step: assert property (@(posedge clk) disable iff (rst)
    (!cpu_r_nw && wr_in_pkt) |-> (cpu_a == prev_wr_a + 16'd1))
  else
  begin
    $error("CPU write address did not advance by one");
    fail_cnt++;
  end

  dbgreg_wr_pulse: assert property (@(posedge clk) disable iff (rst)
    cpu_dbgreg_wr |=> !cpu_dbgreg_wr)  // Single-cycle strobe
  else
  begin
    $error("Debug register write strobe longer than one cycle");
    fail_cnt++;
  end

endmodule

bind hci_top hci_properties u_props
(
  .clk(clk), .rst(rst), .reply_full(reply_full), .reply_valid(reply_valid),
  .active(active), .cpu_r_nw(cpu_r_nw), .cpu_a(cpu_a),
  .cpu_dbgreg_wr(cpu_dbgreg_wr), .state(u_hci_ctrl.state_q)
);

// ==== test/tb_hci.sv ====
`timescale 1ns/1ns

module tb_hci;

  // Echo and block runs stay under 40 bytes, so even at 1 of 2 cycles
  // blocked by reply_full the whole run needs a few thousand cycles
  localparam int MAX_CYCLES = 20000;

  logic        clk, rst, host_valid, reply_full, brk;
  logic [7:0]  host_data, cpu_din, cpu_dbgreg_in;
  logic        host_ready, reply_valid, active, cpu_r_nw, cpu_dbgreg_wr;
  logic [7:0]  reply_data, cpu_dout, cpu_dbgreg_out;
  logic [15:0] cpu_a;
  logic [3:0]  cpu_dbgreg_sel;

  logic [15:0] lfsr = 16'd64983;  // Galois LFSR state
  logic [7:0]  mem_model [65536];  // CPU memory
  logic [7:0]  dbg_regs [16];      // CPU debug registers
  logic [7:0]  exp_q [$];          // Expected reply bytes
  logic [7:0]  sent [$];           // Data bytes of the current block
  logic [3:0]  exp_sel;
  logic [7:0]  exp_val;
  logic [7:0]  bp_bit;
  logic        bp_en = 1'b0;       // Random reply_full on
  logic        timed_out = 1'b0;
  int          errors = 0;
  int          cycles = 0;
  int          wr_pulses = 0;

  hci_top uut (.*);

  assign cpu_din       = mem_model[cpu_a];      // Asynchronous read
  assign cpu_dbgreg_in = dbg_regs[cpu_dbgreg_sel];

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    int         i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // One step per bit
      r    = {r[6:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [7:0] reg_init(input logic [3:0] idx);
    return 8'hA0 ^ {idx, idx};
  endfunction

  task automatic step;
    @(posedge clk);
    #2;  // Drive point after the edge
  endtask

  task automatic push_byte(input logic [7:0] b);
    host_data  = b;
    host_valid = 1'b1;
    while (!host_ready)
      step();
    step();  // Accepted on this edge
    host_valid = 1'b0;
  endtask

  task automatic push_word(input logic [15:0] w);
    push_byte(w[7:0]);  // Low byte first
    push_byte(w[15:8]);
  endtask

  task automatic wait_replies;
    while (exp_q.size() != 0)
      step();
    repeat (2) step();
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else
    begin
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic close_run;
    $display("Errors: %0d testbench, %0d assertion", errors, uut.u_props.fail_cnt);
    if (errors == 0 && uut.u_props.fail_cnt == 0 && !timed_out)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Models and reply checking at the falling edge
  ////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin
    if (!rst && reply_valid)
    begin
      if (exp_q.size() == 0)
      begin
        $display("Reply byte %0h at %0t was not expected", reply_data, $time);
        errors++;
      end
      else
        check_eq("reply_data", exp_q.pop_front(), reply_data);
    end
    if (!rst && !cpu_r_nw)
      mem_model[cpu_a] = cpu_dout;
    if (!rst && cpu_dbgreg_wr)
    begin
      check_eq("cpu_dbgreg_sel", exp_sel, cpu_dbgreg_sel);
      check_eq("cpu_dbgreg_out", exp_val, cpu_dbgreg_out);
      dbg_regs[cpu_dbgreg_sel] = cpu_dbgreg_out;
      wr_pulses++;
    end
  end

  // Back-pressure drawn in a time step of its own
  initial
  begin
    reply_full = 1'b0;
    forever
    begin
      @(posedge clk);
      #1 bp_bit = rand_bits(1);
      #1 reply_full = bp_en && bp_bit[0];
    end
  end

  initial
  begin
    while (cycles < MAX_CYCLES)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, replies still pending: %0d", cycles, exp_q.size());
    timed_out = 1'b1;
    close_run();
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    logic [15:0] a;
    int          n;
    rst        = 1'b1;
    host_valid = 1'b0;
    host_data  = '0;
    brk        = 1'b0;
    exp_sel    = '0;
    exp_val    = '0;
    for (int i = 0; i < 65536; i++)
      mem_model[i] = i[7:0] ^ i[15:8] ^ 8'h5C;  // Whole-address pattern
    for (int i = 0; i < 16; i++)
      dbg_regs[i] = reg_init(i[3:0]);
    repeat (16) step();
    rst = 1'b0;

    // Mode switch through query, brk pulse, run and break opcode
    exp_q.push_back(8'h00);
    push_byte(hci_pkg::QUERY_DBG_BRK);
    wait_replies();
    brk = 1'b1;
    step();
    brk = 1'b0;
    check_eq("active", 1, active);
    exp_q.push_back(8'h01);
    push_byte(hci_pkg::QUERY_DBG_BRK);
    wait_replies();
    push_byte(hci_pkg::DBG_RUN);

    // Memory write packet while idle is dropped
    push_byte(hci_pkg::CPU_MEM_WR);
    push_word(16'h0040);
    push_word(16'h0002);
    push_byte(8'h55);
    push_byte(8'hAA);
    exp_q.push_back(8'h00);
    push_byte(hci_pkg::QUERY_DBG_BRK);
    wait_replies();
    check_eq("active", 0, active);

    push_byte(hci_pkg::DBG_BRK);
    exp_q.push_back(8'h01);
    push_byte(hci_pkg::QUERY_DBG_BRK);
    wait_replies();
    check_eq("active", 1, active);
    exp_q.push_back(8'h00);
    push_byte(hci_pkg::QUERY_ERR_CODE);
    wait_replies();

    // Echo under random back-pressure
    bp_en = 1'b1;
    n = 12 + rand_bits(4);
    push_byte(hci_pkg::ECHO);
    push_word(n[15:0]);
    for (int i = 0; i < n; i++)
    begin
      sent.push_back(rand_bits(8));
      exp_q.push_back(sent[i]);
      push_byte(sent[i]);
    end
    wait_replies();

    // Block write and read back of the same range
    sent.delete();
    a = {rand_bits(8), rand_bits(8)};
    n = 16 + rand_bits(3);
    push_byte(hci_pkg::CPU_MEM_WR);
    push_word(a);
    push_word(n[15:0]);
    for (int i = 0; i < n; i++)
    begin
      sent.push_back(rand_bits(8));
      push_byte(sent[i]);
    end
    exp_q.push_back(8'h00);
    push_byte(hci_pkg::QUERY_ERR_CODE);
    wait_replies();
    for (int i = 0; i < n; i++)
      check_eq("mem_model", sent[i], mem_model[a + i[15:0]]);
    push_byte(hci_pkg::CPU_MEM_RD);
    push_word(a);
    push_word(n[15:0]);
    for (int i = 0; i < n; i++)
      exp_q.push_back(sent[i]);
    wait_replies();

    // Debug register write and two reads
    exp_sel = 4'(rand_bits(4));
    exp_val = rand_bits(8);
    push_byte(hci_pkg::CPU_REG_WR);
    push_byte({4'h0, exp_sel});
    push_byte(exp_val);
    exp_q.push_back(exp_val);
    push_byte(hci_pkg::CPU_REG_RD);
    push_byte({4'h0, exp_sel});
    exp_q.push_back(reg_init(exp_sel ^ 4'h5));
    push_byte(hci_pkg::CPU_REG_RD);
    push_byte({4'h0, exp_sel ^ 4'h5});
    wait_replies();
    check_eq("wr_pulses", 1, wr_pulses);

    // Unknown opcode sets the sticky bit
    push_byte(8'h5A);
    exp_q.push_back(8'h02);
    push_byte(hci_pkg::QUERY_ERR_CODE);
    exp_q.push_back(8'h02);
    push_byte(hci_pkg::QUERY_ERR_CODE);
    wait_replies();
    close_run();
  end

endmodule

// ==== filelist.f ====
common/hci_pkg.sv
host_link/host_fifo.sv
ctrl/xfer_counter.sv
ctrl/hci_ctrl.sv
src/reply_stage.sv
src/hci_top.sv
test/hci_properties.sv
test/tb_hci.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --assert --timing -Wno-fatal --top-module tb_hci \
  -f filelist.f -o tb_hci_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_hci_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '** PASS **'; then
  exit 0
fi
exit 1
